/* hw/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // geometry, 32 sets of 4 ways, 8 words per line
    localparam int tag_width      = 22;
    localparam int index_width    = 5;
    localparam int offset_width   = 5;   // byte offset inside a line
    localparam int way_num        = 4;
    localparam int words_per_line = 8;

    typedef struct packed {
        logic [tag_width-1:0]      tag;
        logic [index_width-1:0]    index;
        logic [offset_width-3:0]   word;
        logic [1:0]                byte_sel;
    } addr_fields_t;

    // fetch address seen either as a plain word or split up
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t fields;
    } fetch_addr_u;

    typedef struct packed {
        logic [31:0] araddr;
        logic [7:0]  arlen;    // beats minus one
        logic        arvalid;
    } mem_ar_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        rlast;
        logic        rvalid;
    } mem_r_t;

    typedef struct packed {
        logic [tag_width-1:0] tag;
        logic                 valid;
    } tag_entry_t;

    // bit 0 picks the pair, bit 1 within ways 0/1, bit 2 within ways 2/3
    typedef logic [2:0] plru_t;

endpackage

`default_nettype wire

/* hw/cache_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ram #(
    parameter int width = 32,
    parameter int depth = 32
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  logic [width-1:0]         wdata,
    input  logic                     re,
    input  logic [$clog2(depth)-1:0] raddr,
    output logic [width-1:0]         rdata
);

    logic [width-1:0] mem [depth];

    initial begin
        for (int i = 0; i < depth; i++) mem[i] = '0;
    end

    // a read to the address being written returns the old word
    always_ff @(posedge clk) begin
        if (we) mem[waddr] <= wdata;
        if (re) rdata <= mem[raddr];   // holds while re is low
    end

endmodule

`default_nettype wire

/* hw/icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache (
    input  logic               clk,
    input  logic               rst,
    input  logic               inst_en,
    input  logic [31:0]        pc_next,
    input  logic [31:0]        pc_f,
    input  logic               stall_f,
    output logic [31:0]        inst_rdata,
    output logic               stall,
    output cache_pkg::mem_ar_t ar,
    input  logic               arready,
    input  cache_pkg::mem_r_t  r,
    output logic               rready
);
    import cache_pkg::*;

    localparam int way_bits = $clog2(way_num);
    localparam int set_num  = 1 << index_width;

    localparam logic [1:0] st_idle  = 2'b00;
    localparam logic [1:0] st_judge = 2'b01;
    localparam logic [1:0] st_load  = 2'b11;

    fetch_addr_u cur_addr;
    fetch_addr_u next_addr;
    logic [1:0]  state;

    tag_entry_t         tag_rd  [way_num];
    logic [31:0]        data_rd [way_num][words_per_line];
    logic [way_num-1:0] valid_q [set_num];   // per set, one bit per way
    plru_t              plru_q  [set_num];

    logic [way_num-1:0]  hit_mask;
    logic [way_bits-1:0] hit_way;
    logic [way_bits-1:0] victim;
    logic [way_bits-1:0] visit_way;
    plru_t               cur_plru;
    tag_entry_t          tag_wdata;

    logic lookup;
    logic hit;
    logic miss;
    logic ram_re;
    logic read_req;
    logic addr_rcv;
    logic beat_ok;
    logic read_finish;
    logic [offset_width-3:0] beat_cnt;
    logic [31:0]             saved_word;

    assign cur_addr.raw  = pc_f;
    assign next_addr.raw = pc_next;

    // RAM outputs belong to pc_f one cycle after the read
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < way_num; w++) begin
            hit_mask[w] = valid_q[cur_addr.fields.index][w] & tag_rd[w].valid
                        & (tag_rd[w].tag == cur_addr.fields.tag);
            if (hit_mask[w]) hit_way = way_bits'(w);
        end
    end

    assign lookup = (state == st_judge) & inst_en;
    assign hit    = lookup & (|hit_mask);
    assign miss   = lookup & ~(|hit_mask);

    assign stall      = miss | (state == st_load);
    assign inst_rdata = hit ? data_rd[hit_way][cur_addr.fields.word] : saved_word;

    // tree walk toward the least recently used way
    assign cur_plru  = plru_q[cur_addr.fields.index];
    assign victim    = {cur_plru[0], cur_plru[0] ? cur_plru[2] : cur_plru[1]};
    assign visit_way = hit ? hit_way : victim;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:  if (!stall_f) state <= st_judge;
                st_judge: if (miss) state <= st_load;
                st_load:  if (read_finish) state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    // burst read of the whole line
    assign beat_ok     = addr_rcv & r.rvalid & rready;
    assign read_finish = beat_ok & r.rlast;

    assign ar.araddr  = {cur_addr.fields.tag, cur_addr.fields.index, {offset_width{1'b0}}};
    assign ar.arlen   = 8'(words_per_line - 1);
    assign ar.arvalid = read_req & ~addr_rcv;
    assign rready     = addr_rcv;

    always_ff @(posedge clk) begin
        if (rst) begin
            read_req <= 1'b0;
            addr_rcv <= 1'b0;
            beat_cnt <= '0;
        end else begin
            if (miss) read_req <= 1'b1;
            else if (read_finish) read_req <= 1'b0;

            if (ar.arvalid && arready) addr_rcv <= 1'b1;
            else if (read_finish) addr_rcv <= 1'b0;

            if (read_finish) beat_cnt <= '0;
            else if (beat_ok) beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // requested word grabbed as it passes by
    always_ff @(posedge clk) begin
        if (beat_ok && beat_cnt == cur_addr.fields.word) saved_word <= r.rdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < set_num; s++) begin
                valid_q[s] <= '0;
                plru_q[s]  <= '0;
            end
        end else begin
            if (read_finish) valid_q[cur_addr.fields.index][victim] <= 1'b1;
            if (hit || read_finish) begin
                // point away from the way just used
                plru_q[cur_addr.fields.index][0] <= ~visit_way[1];
                if (visit_way[1]) plru_q[cur_addr.fields.index][2] <= ~visit_way[0];
                else plru_q[cur_addr.fields.index][1] <= ~visit_way[0];
            end
        end
    end

    assign tag_wdata = '{tag: cur_addr.fields.tag, valid: 1'b1};
    assign ram_re    = ~stall_f;   // frozen during a miss

    for (genvar w = 0; w < way_num; w++) begin : g_way
        logic tag_we;

        assign tag_we = read_finish & (victim == way_bits'(w));

        cache_ram #(
            .width ($bits(tag_entry_t)),
            .depth (set_num)
        ) u_tag (
            .clk   (clk),
            .we    (tag_we),
            .waddr (cur_addr.fields.index),
            .wdata (tag_wdata),
            .re    (ram_re),
            .raddr (next_addr.fields.index),
            .rdata (tag_rd[w])
        );

        for (genvar b = 0; b < words_per_line; b++) begin : g_bank
            logic bank_we;

            assign bank_we = beat_ok & (victim == way_bits'(w))
                           & (beat_cnt == (offset_width-2)'(b));

            cache_ram #(
                .width (32),
                .depth (set_num)
            ) u_bank (
                .clk   (clk),
                .we    (bank_we),
                .waddr (cur_addr.fields.index),
                .wdata (r.rdata),
                .re    (ram_re),
                .raddr (next_addr.fields.index),
                .rdata (data_rd[w][b])
            );
        end
    end

    a_ar_stable: assert property (@(posedge clk) disable iff (rst)
        ar.arvalid && !arready |=> $stable(ar));

    // tags within a set stay unique since only a miss fills
    a_one_hit: assert property (@(posedge clk) disable iff (rst)
        state == st_judge |-> $onehot0(hit_mask));

endmodule

`default_nettype wire

/* hw/read_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module read_arbiter #(
    parameter int num_ports = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  cache_pkg::mem_ar_t req_ar      [num_ports],
    output logic               req_arready [num_ports],
    output cache_pkg::mem_r_t  req_r       [num_ports],
    input  logic               req_rready  [num_ports],
    output cache_pkg::mem_ar_t mem_ar,
    input  logic               mem_arready,
    input  cache_pkg::mem_r_t  mem_r,
    output logic               mem_rready
);

    localparam int pw = (num_ports > 1) ? $clog2(num_ports) : 1;

    logic [pw-1:0] owner_q;     // holder of the bus
    logic [pw-1:0] rr_q;        // last owner, search starts after it
    logic [pw-1:0] grant_idx;
    logic [pw-1:0] cur;
    logic          busy_q;      // address accepted, beats pending
    logic          wait_q;      // address shown but not yet accepted
    logic          grant_vld;
    logic          free;
    logic          last_hs;

    always_comb begin
        int cand;
        grant_vld = 1'b0;
        grant_idx = rr_q;
        for (int k = 1; k <= num_ports; k++) begin
            cand = (int'(rr_q) + k) % num_ports;
            if (!grant_vld && req_ar[cand].arvalid) begin
                grant_vld = 1'b1;
                grant_idx = pw'(cand);
            end
        end
    end

    assign free    = ~busy_q & ~wait_q;
    assign cur     = free ? grant_idx : owner_q;   // locked once shown on the bus
    assign mem_ar  = (~busy_q & (wait_q | grant_vld)) ? req_ar[cur] : '0;
    assign last_hs = busy_q & mem_r.rvalid & mem_rready & mem_r.rlast;

    assign mem_rready = busy_q & req_rready[owner_q];

    for (genvar i = 0; i < num_ports; i++) begin : g_port
        assign req_arready[i] = ~busy_q & (cur == pw'(i)) & mem_ar.arvalid & mem_arready;
        assign req_r[i] = '{rdata:  mem_r.rdata,
                            rlast:  mem_r.rlast,
                            rvalid: mem_r.rvalid & busy_q & (owner_q == pw'(i))};

        // a beat only goes to the cache that is waiting for its line
        a_r_owner: assert property (@(posedge clk) disable iff (rst)
            req_r[i].rvalid |-> req_rready[i]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            owner_q <= '0;
            rr_q    <= pw'(num_ports - 1);   // port 0 first
            busy_q  <= 1'b0;
            wait_q  <= 1'b0;
        end else begin
            if (free && grant_vld) owner_q <= grant_idx;
            if (!busy_q && mem_ar.arvalid) begin
                busy_q <= mem_arready;
                wait_q <= ~mem_arready;
            end else if (last_hs) begin
                busy_q <= 1'b0;
                rr_q   <= owner_q;
            end
        end
    end

    // the request on the bus does not switch until the memory takes it
    a_grant_hold: assert property (@(posedge clk) disable iff (rst)
        mem_ar.arvalid && !mem_arready |=> $stable(mem_ar));

endmodule

`default_nettype wire

/* hw/fetch_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_subsys_top (
    input  logic               clk,
    input  logic               rst,
    // core 0
    input  logic               inst_en_0,
    input  logic [31:0]        pc_next_0,
    input  logic [31:0]        pc_f_0,
    input  logic               stall_f_0,
    output logic [31:0]        inst_rdata_0,
    output logic               stall_0,
    // core 1
    input  logic               inst_en_1,
    input  logic [31:0]        pc_next_1,
    input  logic [31:0]        pc_f_1,
    input  logic               stall_f_1,
    output logic [31:0]        inst_rdata_1,
    output logic               stall_1,
    // shared memory bus
    output cache_pkg::mem_ar_t mem_ar,
    input  logic               mem_arready,
    input  cache_pkg::mem_r_t  mem_r,
    output logic               mem_rready
);
    import cache_pkg::*;

    localparam int num_ports = 2;

    mem_ar_t core_ar      [num_ports];
    logic    core_arready [num_ports];
    mem_r_t  core_r       [num_ports];
    logic    core_rready  [num_ports];

    icache core0 (
        .clk        (clk),
        .rst        (rst),
        .inst_en    (inst_en_0),
        .pc_next    (pc_next_0),
        .pc_f       (pc_f_0),
        .stall_f    (stall_f_0),
        .inst_rdata (inst_rdata_0),
        .stall      (stall_0),
        .ar         (core_ar[0]),
        .arready    (core_arready[0]),
        .r          (core_r[0]),
        .rready     (core_rready[0])
    );

    icache core1 (
        .clk        (clk),
        .rst        (rst),
        .inst_en    (inst_en_1),
        .pc_next    (pc_next_1),
        .pc_f       (pc_f_1),
        .stall_f    (stall_f_1),
        .inst_rdata (inst_rdata_1),
        .stall      (stall_1),
        .ar         (core_ar[1]),
        .arready    (core_arready[1]),
        .r          (core_r[1]),
        .rready     (core_rready[1])
    );

    // one burst at a time on the memory side
    read_arbiter #(
        .num_ports (num_ports)
    ) u_arb (
        .clk         (clk),
        .rst         (rst),
        .req_ar      (core_ar),
        .req_arready (core_arready),
        .req_r       (core_r),
        .req_rready  (core_rready),
        .mem_ar      (mem_ar),
        .mem_arready (mem_arready),
        .mem_r       (mem_r),
        .mem_rready  (mem_rready)
    );

endmodule

`default_nettype wire

/* sim/tb_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
    input  logic               clk,
    input  logic               rst,
    input  cache_pkg::mem_ar_t mem_ar,
    output logic               mem_arready,
    output cache_pkg::mem_r_t  mem_r,
    input  logic               mem_rready,
    output int                 burst_count,
    output logic               overlap
);
    import cache_pkg::*;

    logic [31:0] lfsr;
    logic [31:0] base;
    logic [7:0]  len;
    logic [7:0]  beat;
    logic        busy;   // burst accepted, beats still owed
    logic        arready_q = 1'b0;
    mem_r_t      r_q = '0;

    assign mem_arready = arready_q;
    assign mem_r       = r_q;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // every word is a fixed scramble of its own byte address
    function automatic logic [31:0] mix_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ (a >> 7) ^ 32'h5a5a_c3c3;
    endfunction

    task automatic next_bit(output bit b);
        b = lfsr[0];
        lfsr = lfsr_step(lfsr);
    endtask

    always @(posedge clk) begin
        bit b0;
        bit b1;
        logic [31:0] nxt;
        if (rst) begin
            lfsr = 32'hb407_6a6e;
            busy        <= 1'b0;
            arready_q   <= 1'b0;
            r_q         <= '0;
            beat        <= '0;
            burst_count <= 0;
            overlap     <= 1'b0;
        end else begin
            if (busy && mem_ar.arvalid) overlap <= 1'b1;   // second request mid burst
            if (!busy) begin
                if (mem_ar.arvalid && arready_q) begin
                    busy        <= 1'b1;
                    base        <= mem_ar.araddr;
                    len         <= mem_ar.arlen;
                    beat        <= '0;
                    burst_count <= burst_count + 1;
                    arready_q   <= 1'b0;
                    next_bit(b0);
                    r_q <= '{rdata: mix_word(mem_ar.araddr),
                             rlast: (mem_ar.arlen == 8'd0), rvalid: b0};
                end else begin
                    next_bit(b0);
                    next_bit(b1);
                    arready_q <= !(b0 && b1);   // withheld one time in four
                end
            end else if (r_q.rvalid && mem_rready) begin
                if (r_q.rlast) begin
                    busy <= 1'b0;
                    r_q  <= '0;
                end else begin
                    next_bit(b0);
                    nxt = base + 32'(4 * (int'(beat) + 1));
                    beat <= beat + 8'd1;
                    r_q  <= '{rdata: mix_word(nxt),
                              rlast: ((beat + 8'd1) == len), rvalid: b0};
                end
            end else if (!r_q.rvalid) begin
                next_bit(b0);
                r_q.rvalid <= b0;   // data already set up for this beat
            end
        end
    end

endmodule

`default_nettype wire

/* sim/tb_fetch_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_subsys;
    import cache_pkg::*;

    typedef struct packed {
        logic [1:0]  mask;   // bit per core
        logic [31:0] a0;
        logic [31:0] a1;
    } fetch_entry_t;

    logic clk = 1'b0;
    logic rst;
    logic inst_en_0 = 1'b0;
    logic inst_en_1 = 1'b0;
    logic stall_f_0;
    logic stall_f_1;
    logic stall_0;
    logic stall_1;
    logic [31:0] pc_next_0;
    logic [31:0] pc_next_1;
    logic [31:0] pc_f_0 = '0;
    logic [31:0] pc_f_1 = '0;
    logic [31:0] inst_rdata_0;
    logic [31:0] inst_rdata_1;
    logic en_next_0;
    logic en_next_1;
    mem_ar_t mem_ar;
    mem_r_t  mem_r;
    logic mem_arready;
    logic mem_rready;
    logic overlap;
    int   burst_count;

    fetch_entry_t table_q[$];
    logic [tag_width-1:0] m_tag [2][32][4];
    bit   m_valid [2][32][4];
    plru_t m_plru [2][32];
    int   misses [2];
    int   cycles = 0;
    int   limit  = 0;

    fetch_subsys_top uut (
        .clk(clk), .rst(rst),
        .inst_en_0(inst_en_0), .pc_next_0(pc_next_0), .pc_f_0(pc_f_0),
        .stall_f_0(stall_f_0), .inst_rdata_0(inst_rdata_0), .stall_0(stall_0),
        .inst_en_1(inst_en_1), .pc_next_1(pc_next_1), .pc_f_1(pc_f_1),
        .stall_f_1(stall_f_1), .inst_rdata_1(inst_rdata_1), .stall_1(stall_1),
        .mem_ar(mem_ar), .mem_arready(mem_arready), .mem_r(mem_r), .mem_rready(mem_rready)
    );

    tb_mem_model mem (
        .clk(clk), .rst(rst), .mem_ar(mem_ar), .mem_arready(mem_arready),
        .mem_r(mem_r), .mem_rready(mem_rready), .burst_count(burst_count), .overlap(overlap)
    );

    always #10 clk = ~clk;

    assign stall_f_0 = stall_0;   // core freezes on its own stall
    assign stall_f_1 = stall_1;

    // fetch stage register of each core
    always @(posedge clk) begin
        if (rst) begin
            pc_f_0 <= '0;
            pc_f_1 <= '0;
            inst_en_0 <= 1'b0;
            inst_en_1 <= 1'b0;
        end else begin
            if (!stall_0) begin
                pc_f_0 <= pc_next_0;
                inst_en_0 <= en_next_0;
            end
            if (!stall_1) begin
                pc_f_1 <= pc_next_1;
                inst_en_1 <= en_next_1;
            end
        end
    end

    function automatic logic [31:0] expected_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ (a >> 7) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [31:0] line_of(input logic [31:0] a);
        return {a[31:5], 5'b0};
    endfunction

    task automatic report_fail(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input logic [31:0] act, input logic [31:0] exp, input string msg);
        if (act !== exp)
            report_fail($sformatf("%s: got %08h, expected %08h", msg, act, exp));
    endtask

    task automatic check_ar(input mem_ar_t act, input mem_ar_t exp, input string msg);
        if (act !== exp)
            report_fail($sformatf("%s: got %h/%0d, expected %h/%0d", msg,
                                  act.araddr, act.arlen, exp.araddr, exp.arlen));
    endtask

    task automatic check_count(input int act, input int exp, input string msg);
        if (act != exp)
            report_fail($sformatf("%s: got %0d, expected %0d", msg, act, exp));
    endtask

    // reference cache, tree pseudo-LRU over four ways
    task automatic model_access(input int c, input logic [31:0] a);
        fetch_addr_u fa;
        int   way;
        bit   found;
        plru_t p;
        fa.raw = a;
        found = 0;
        way = 0;
        p = m_plru[c][fa.fields.index];
        for (int w = 0; w < 4; w++) begin
            if (m_valid[c][fa.fields.index][w]
                    && m_tag[c][fa.fields.index][w] == fa.fields.tag) begin
                found = 1;
                way = w;
            end
        end
        if (!found) begin
            // bit 0 names the pair, bit 1 or bit 2 the way inside it
            if (!p[0]) way = p[1] ? 1 : 0;
            else way = p[2] ? 3 : 2;
            m_valid[c][fa.fields.index][way] = 1;
            m_tag[c][fa.fields.index][way] = fa.fields.tag;
            misses[c]++;
        end
        if (way < 2) begin   // aim the tree at the other side
            p[0] = 1'b1;
            p[1] = (way == 0);
        end else begin
            p[0] = 1'b0;
            p[2] = (way == 2);
        end
        m_plru[c][fa.fields.index] = p;
    endtask

    task automatic add_entry(input logic [1:0] mask, input logic [31:0] a0, input logic [31:0] a1);
        table_q.push_back('{mask: mask, a0: a0, a1: a1});
    endtask

    // every accepted burst must be a line-aligned request of a stalled core
    always @(negedge clk) begin
        mem_ar_t exp;
        if (!rst && mem_ar.arvalid && mem_arready) begin
            exp.arlen = 8'd7;
            exp.arvalid = 1'b1;
            if (stall_0 && line_of(pc_f_0) == mem_ar.araddr) exp.araddr = line_of(pc_f_0);
            else exp.araddr = line_of(pc_f_1);
            check_ar(mem_ar, exp, "burst request");
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: fetches did not finish within %0d cycles", limit);
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

    initial begin
        fetch_entry_t e;
        logic [1:0] done;
        rst = 1'b1;
        pc_next_0 = '0;
        pc_next_1 = '0;
        en_next_0 = 1'b0;
        en_next_1 = 1'b0;
        misses[0] = 0;
        misses[1] = 0;
        for (int c = 0; c < 2; c++) begin
            for (int s = 0; s < 32; s++)
                m_plru[c][s] = '0;
        end

        add_entry(2'b01, 32'h0000_1004, 0);   // cold miss, then same line
        add_entry(2'b01, 32'h0000_1000, 0);
        add_entry(2'b01, 32'h0000_101c, 0);
        add_entry(2'b01, 32'h0000_1008, 0);
        add_entry(2'b01, 32'h0000_0464, 0);   // five tags into set 3
        add_entry(2'b01, 32'h0000_0868, 0);
        add_entry(2'b01, 32'h0000_0c60, 0);
        add_entry(2'b01, 32'h0000_107c, 0);
        add_entry(2'b01, 32'h0000_1470, 0);
        add_entry(2'b01, 32'h0000_0464, 0);
        add_entry(2'b01, 32'h0000_0868, 0);
        add_entry(2'b11, 32'h0000_2000, 32'h0000_2000);   // both cores at once
        add_entry(2'b11, 32'h0000_3010, 32'h0000_2004);
        add_entry(2'b11, 32'h0000_3014, 32'h0000_3018);
        add_entry(2'b10, 0, 32'h0000_1464);
        add_entry(2'b11, 32'h0000_0c60, 32'h0000_0464);
        for (int i = 1; i <= 16; i++)
            add_entry(2'b11, (i * 32'h0000_0d64) & 32'h0000_1ffc,
                      (i * 32'h0000_0b28) & 32'h0000_1ffc);
        limit = table_q.size() * (words_per_line + 40);

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // idle after reset
        repeat (5) begin
            @(negedge clk);
            check_count(int'(stall_0), 0, "stall_0 idle");
            check_count(int'(stall_1), 0, "stall_1 idle");
            check_count(int'(mem_ar.arvalid), 0, "arvalid idle");
            check_count(int'(mem_rready), 0, "rready idle");
        end

        foreach (table_q[i]) begin
            e = table_q[i];
            @(posedge clk);
            pc_next_0 <= e.a0;
            pc_next_1 <= e.a1;
            en_next_0 <= e.mask[0];
            en_next_1 <= e.mask[1];
            done = ~e.mask;
            while (done != 2'b11) begin
                @(negedge clk);
                if (!done[0] && inst_en_0 && pc_f_0 == e.a0 && !stall_0) begin
                    check_word(inst_rdata_0, expected_word(e.a0), $sformatf("core0 %h", e.a0));
                    model_access(0, e.a0);
                    done[0] = 1'b1;
                end
                if (!done[1] && inst_en_1 && pc_f_1 == e.a1 && !stall_1) begin
                    check_word(inst_rdata_1, expected_word(e.a1), $sformatf("core1 %h", e.a1));
                    model_access(1, e.a1);
                    done[1] = 1'b1;
                end
            end
            check_count(burst_count, misses[0] + misses[1], $sformatf("bursts after entry %0d", i));
            check_count(int'(overlap), 0, "burst overlap");
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
hw/cache_pkg.sv
hw/cache_ram.sv
hw/icache.sv
hw/read_arbiter.sv
hw/fetch_subsys_top.sv
sim/tb_mem_model.sv
sim/tb_fetch_subsys.sv

/* Makefile */
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -f sim.f --top-module tb_fetch_subsys \
		-Mdir $(OBJ_DIR) -o sim_bin

run: compile
	./$(OBJ_DIR)/sim_bin | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
